/* design/adc_frontend.sv */
// raw ADC word to signed sample, arithmetic shift right by ADC_SHIFT
// the top raw bit is taken as sign, raw words arrive already parallel
// digital loopback swaps in the DAC sum of the same cycle
// one register stage, adc_dat_o follows adc_raw_i by 1 cycle

module adc_frontend (
  input  logic              adc_clk,
  input  logic              rst_i,
  input  rp_pkg::raw_pair_t adc_raw_i,
  input  rp_pkg::smp_pair_t loop_dat_i,      // unregistered DAC sum
  input  logic              digital_loop_i,  // from hk
  output rp_pkg::smp_pair_t adc_dat_o
);

  import rp_pkg::*;

  smp_pair_t adc_conv;  // shifted samples
  smp_pair_t adc_sel;   // after loopback mux

  // sign fill comes from >>> on the signed view
  function automatic sample_t raw_to_smp(adc_raw_t raw);
    return sample_t'($signed(raw) >>> ADC_SHIFT);
  endfunction

  assign adc_conv.a = raw_to_smp(adc_raw_i.a);
  assign adc_conv.b = raw_to_smp(adc_raw_i.b);

  assign adc_sel = digital_loop_i ? loop_dat_i : adc_conv;  // raw input ignored in loop

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      adc_dat_o <= '0;
    else
      adc_dat_o <= adc_sel;
  end

endmodule

/* design/dac_mixer.sv */
// generator sample plus dc offset, saturated to 14 bits per channel
// two register stages to the pins, dac_dat_o lags asg_dat_i by 2 cycles
// loop_dat_o is the saturated sum before any register
// dac_reset_o is rst_i delayed by one cycle

module dac_mixer (
  input  logic              adc_clk,
  input  logic              rst_i,
  input  rp_pkg::smp_pair_t asg_dat_i,  // generator samples
  input  rp_pkg::smp_pair_t offset_i,   // from offset regs
  output rp_pkg::smp_pair_t loop_dat_o,
  output rp_pkg::smp_pair_t dac_dat_o,
  output logic              dac_reset_o
);

  import rp_pkg::*;

  smp_pair_t dac_sat;   // saturated sums
  smp_pair_t dac_s1_q;  // first stage

  // add with one guard bit, clamp when the two top bits disagree
  function automatic sample_t sat_add(sample_t x, sample_t y);
    logic signed [SUM_W-1:0] sum;
    sum = SUM_W'(x) + SUM_W'(y);
    if (sum[SUM_W-1] ^ sum[SUM_W-2])
      return {sum[SUM_W-1], {(SMP_W-1){~sum[SUM_W-1]}}};  // 0x2000 or 0x1fff
    return sum[SMP_W-1:0];
  endfunction

  assign dac_sat.a  = sat_add(asg_dat_i.a, offset_i.a);
  assign dac_sat.b  = sat_add(asg_dat_i.b, offset_i.b);
  assign loop_dat_o = dac_sat;  // feeds the ADC loopback

  ////////////////////////////////////////////////////////////
  // output pipeline
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      dac_s1_q  <= '0;
      dac_dat_o <= '0;  // mid scale while in reset
    end
    else
    begin
      dac_s1_q  <= dac_sat;
      dac_dat_o <= dac_s1_q;
    end
  end

  // converter reset, one cycle behind the system reset
  always_ff @(posedge adc_clk)
  begin
    dac_reset_o <= rst_i;
  end

endmodule

/* design/dac_offset_regs.sv */
// dc offset region, one signed 14 bit register per DAC channel
// writes keep wdata[13:0], reads return it sign extended to 32 bits
// unknown offsets ack with err

module dac_offset_regs (
  input  logic              adc_clk,
  input  logic              rst_i,
  input  rp_pkg::sys_req_t  req_i,    // offset only in addr
  output rp_pkg::sys_rsp_t  rsp_o,
  output rp_pkg::smp_pair_t offset_o  // to the DAC adder
);

  import rp_pkg::*;

  logic [REG_OFS_W-1:0] ofs;
  logic                 ofs_hit;
  logic [SYS_DW-1:0]    rd_val;
  smp_pair_t            offset_q;

  assign ofs = req_i.addr[REG_OFS_W-1:0];

  always_comb
  begin
    ofs_hit = 1'b1;
    rd_val  = '0;
    case (ofs)  // sign extend on read
      DCO_ADDR_A: rd_val = {{(SYS_DW-SMP_W){offset_q.a[SMP_W-1]}}, offset_q.a};
      DCO_ADDR_B: rd_val = {{(SYS_DW-SMP_W){offset_q.b[SMP_W-1]}}, offset_q.b};
      default:    ofs_hit = 1'b0;
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      offset_q <= '0;  // no offset after reset
      rsp_o    <= '0;
    end
    else
    begin
      rsp_o.ack   <= req_i.wen | req_i.ren;
      rsp_o.err   <= (req_i.wen | req_i.ren) & ~ofs_hit;
      rsp_o.rdata <= req_i.ren ? rd_val : '0;
      if (req_i.wen && ofs == DCO_ADDR_A)
        offset_q.a <= req_i.wdata[SMP_W-1:0];  // upper bits dropped
      if (req_i.wen && ofs == DCO_ADDR_B)
        offset_q.b <= req_i.wdata[SMP_W-1:0];
    end
  end

  assign offset_o = offset_q;

endmodule

/* design/hk_regs.sv */
// housekeeping region: id, digital loopback flag and leds
// id is read only, a write to it is acked and dropped
// unknown offsets ack with err, rdata stays zero on writes and errors

module hk_regs (
  input  logic                     adc_clk,
  input  logic                     rst_i,
  input  rp_pkg::sys_req_t         req_i,  // offset only in addr
  output rp_pkg::sys_rsp_t         rsp_o,
  output logic                     digital_loop_o,
  output logic [rp_pkg::LED_W-1:0] led_o
);

  import rp_pkg::*;

  logic [REG_OFS_W-1:0] ofs;
  logic                 ofs_hit;  // offset is one of ours
  logic [SYS_DW-1:0]    rd_val;
  logic                 loop_q;
  logic [LED_W-1:0]     led_q;

  assign ofs = req_i.addr[REG_OFS_W-1:0];

  // address decode and read mux
  always_comb
  begin
    ofs_hit = 1'b1;
    rd_val  = '0;
    case (ofs)
      HK_ADDR_ID:   rd_val = HK_ID;
      HK_ADDR_LOOP: rd_val = SYS_DW'(loop_q);
      HK_ADDR_LED:  rd_val = SYS_DW'(led_q);
      default:      ofs_hit = 1'b0;
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      loop_q <= 1'b0;
      led_q  <= '0;
      rsp_o  <= '0;
    end
    else
    begin
      rsp_o.ack   <= req_i.wen | req_i.ren;              // 1 cycle latency
      rsp_o.err   <= (req_i.wen | req_i.ren) & ~ofs_hit;
      rsp_o.rdata <= req_i.ren ? rd_val : '0;            // zero on miss too
      if (req_i.wen)
      begin
        case (ofs)
          HK_ADDR_LOOP: loop_q <= req_i.wdata[0];
          HK_ADDR_LED:  led_q  <= req_i.wdata[LED_W-1:0];
          default:      ;  // id and unknown offsets ignored
        endcase
      end
    end
  end

  assign digital_loop_o = loop_q;
  assign led_o          = led_q;

endmodule

/* design/rp_pkg.sv */
// shared widths, address map and bus/sample types for the adc_clk datapath
// everything runs on adc_clk, the bus included
// region index sits in address bits 22..20, the offset in bits 19..0
// samples are two's complement, 14 bits, channel a in the upper half of a pair

package rp_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  localparam int SMP_W     = 14;  // DAC/ADC sample
  localparam int SUM_W     = 15;  // one guard bit for the offset adder
  localparam int ADC_SHIFT = 2;   // raw word to sample, arithmetic
  localparam int SYS_AW    = 32;
  localparam int SYS_DW    = 32;
  localparam int REG_OFS_W = 20;  // offset bits within a region
  localparam int REGION_N  = 8;
  localparam int REGION_W  = 3;
  localparam int LED_W     = 8;

  ////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////

  localparam logic [REGION_W-1:0] REGION_HK  = 3'd0;  // housekeeping
  localparam logic [REGION_W-1:0] REGION_DCO = 3'd1;  // dc offsets

  localparam logic [SYS_DW-1:0] HK_ID = 32'h5250_0001;  // read only

  localparam logic [REG_OFS_W-1:0] HK_ADDR_ID   = 20'h0_0000;
  localparam logic [REG_OFS_W-1:0] HK_ADDR_LOOP = 20'h0_0004;  // bit 0 only
  localparam logic [REG_OFS_W-1:0] HK_ADDR_LED  = 20'h0_0008;
  localparam logic [REG_OFS_W-1:0] DCO_ADDR_A   = 20'h0_0000;
  localparam logic [REG_OFS_W-1:0] DCO_ADDR_B   = 20'h0_0004;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  typedef logic signed [SMP_W-1:0] sample_t;
  typedef logic        [SMP_W-1:0] adc_raw_t;  // straight from the converter

  typedef struct packed {
    sample_t a;
    sample_t b;
  } smp_pair_t;

  typedef struct packed {
    adc_raw_t a;
    adc_raw_t b;
  } raw_pair_t;

  // one request per cycle, wen and ren never together
  typedef struct packed {
    logic [SYS_AW-1:0] addr;
    logic [SYS_DW-1:0] wdata;
    logic              wen;
    logic              ren;
  } sys_req_t;

  // ack pulses one cycle after the strobe, rdata zero unless a good read
  typedef struct packed {
    logic [SYS_DW-1:0] rdata;
    logic              ack;
    logic              err;
  } sys_rsp_t;

endpackage

/* design/rp_top.sv */
// fast analog top level, single clock domain on adc_clk
// bus latency is 1 cycle strobe to ack, one request in flight at a time
// adc_dat_o lags adc_raw_i by 1 cycle, dac_dat_o lags asg_dat_i by 2
// no back-pressure anywhere

module rp_top (
  input  logic                     adc_clk,
  input  logic                     rst_i,
  // system bus
  input  rp_pkg::sys_req_t         sys_req_i,
  output rp_pkg::sys_rsp_t         sys_rsp_o,
  // analog datapath
  input  rp_pkg::raw_pair_t        adc_raw_i,
  input  rp_pkg::smp_pair_t        asg_dat_i,
  output rp_pkg::smp_pair_t        adc_dat_o,
  output rp_pkg::smp_pair_t        dac_dat_o,
  output logic                     dac_reset_o,
  output logic [rp_pkg::LED_W-1:0] led_o
);

  import rp_pkg::*;

  sys_req_t  hk_req, dco_req;  // per region requests
  sys_rsp_t  hk_rsp, dco_rsp;
  smp_pair_t dco_offset;       // programmable dc offsets
  smp_pair_t loop_dat;         // saturated DAC sum for loopback
  logic      digital_loop;

  ////////////////////////////////////////////////////////////
  // system bus
  ////////////////////////////////////////////////////////////

  sys_bus_decoder i_sys_dec (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .m_req_i   (sys_req_i),
    .m_rsp_o   (sys_rsp_o),
    .hk_req_o  (hk_req),
    .hk_rsp_i  (hk_rsp),
    .dco_req_o (dco_req),
    .dco_rsp_i (dco_rsp)
  );

  hk_regs i_hk (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .req_i          (hk_req),
    .rsp_o          (hk_rsp),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  dac_offset_regs i_dco (
    .adc_clk  (adc_clk),
    .rst_i    (rst_i),
    .req_i    (dco_req),
    .rsp_o    (dco_rsp),
    .offset_o (dco_offset)
  );

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////

  adc_frontend i_adc (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .adc_raw_i      (adc_raw_i),
    .loop_dat_i     (loop_dat),
    .digital_loop_i (digital_loop),
    .adc_dat_o      (adc_dat_o)
  );

  dac_mixer i_dac (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .asg_dat_i   (asg_dat_i),
    .offset_i    (dco_offset),
    .loop_dat_o  (loop_dat),
    .dac_dat_o   (dac_dat_o),
    .dac_reset_o (dac_reset_o)
  );

endmodule

/* design/sys_bus_decoder.sv */
// splits the system bus into REGION_N regions of 2**REG_OFS_W bytes
// only hk and dco regions are mapped, the rest answer ack with err
// master must wait for ack before the next strobe, the region index
// of a request is held until the next one

module sys_bus_decoder (
  input  logic             adc_clk,
  input  logic             rst_i,
  input  rp_pkg::sys_req_t m_req_i,    // from master
  output rp_pkg::sys_rsp_t m_rsp_o,
  output rp_pkg::sys_req_t hk_req_o,   // region 0
  input  rp_pkg::sys_rsp_t hk_rsp_i,
  output rp_pkg::sys_req_t dco_req_o,  // region 1
  input  rp_pkg::sys_rsp_t dco_rsp_i
);

  import rp_pkg::*;

  logic [REGION_W-1:0] region;      // index of current request
  logic [REGION_W-1:0] region_q;    // index of last request, steers response
  logic [REGION_N-1:0] region_hot;  // one-hot decode
  logic                strobe;
  logic                unmapped;
  sys_req_t            sub_req;     // request with region bits stripped
  logic                err_q;       // own ack with err for unmapped regions

  ////////////////////////////////////////////////////////////
  // request side, combinational
  ////////////////////////////////////////////////////////////

  assign region     = m_req_i.addr[REG_OFS_W +: REGION_W];  // bits 22..20
  assign region_hot = REGION_N'(1) << region;
  assign strobe     = m_req_i.wen | m_req_i.ren;
  assign unmapped   = ~(region_hot[REGION_HK] | region_hot[REGION_DCO]);

  always_comb
  begin
    sub_req      = m_req_i;
    sub_req.addr = SYS_AW'(m_req_i.addr[REG_OFS_W-1:0]);  // offset only
    hk_req_o     = sub_req;
    dco_req_o    = sub_req;
    // strobes reach the addressed region only
    hk_req_o.wen  = sub_req.wen & region_hot[REGION_HK];
    hk_req_o.ren  = sub_req.ren & region_hot[REGION_HK];
    dco_req_o.wen = sub_req.wen & region_hot[REGION_DCO];
    dco_req_o.ren = sub_req.ren & region_hot[REGION_DCO];
  end

  ////////////////////////////////////////////////////////////
  // response side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      region_q <= REGION_HK;  // hk rsp is idle after reset
      err_q    <= 1'b0;
    end
    else
    begin
      if (strobe)
        region_q <= region;
      err_q <= strobe & unmapped;
    end
  end

  always_comb
  begin
    case (region_q)
      REGION_HK:  m_rsp_o = hk_rsp_i;
      REGION_DCO: m_rsp_o = dco_rsp_i;
      default:                  // regions 2..7
      begin
        m_rsp_o     = '0;       // never data on error
        m_rsp_o.ack = err_q;
        m_rsp_o.err = err_q;
      end
    endcase
  end

endmodule

/* tb.f */
design/rp_pkg.sv
design/sys_bus_decoder.sv
design/hk_regs.sv
design/dac_offset_regs.sv
design/adc_frontend.sv
design/dac_mixer.sv
design/rp_top.sv
verif/rp_top_tb.sv

/* verif/rp_top_tb.sv */
// table-driven testbench for rp_top, one row per bus access or sample vector
// inputs change on the rising edge, outputs are checked on the falling edge
// the model tracks the register state from the bus writes in the table
// expected adc/dac values are rebuilt per cycle with 1 and 2 cycle delays
// stops at the first mismatch, a watchdog covers hangs

module rp_top_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import rp_pkg::*;

  typedef struct packed {
    logic        is_bus;     // bus access or sample vector
    logic        wen;        // read when low
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic        exp_err;
    raw_pair_t   raw;
    smp_pair_t   asg;
  } row_t;

  logic             adc_clk;
  logic             rst_i;
  sys_req_t         sys_req;
  sys_rsp_t         sys_rsp;
  raw_pair_t        adc_raw;
  smp_pair_t        asg_dat, adc_dat, dac_dat;
  logic             dac_reset;
  logic [LED_W-1:0] led;

  row_t             tbl[$];
  bit               tbl_ready;
  logic [31:0]      rnd = 32'd77904;
  // model state
  smp_pair_t        m_off, exp_adc, exp_dac1, exp_dac2;
  logic             m_loop;
  logic [LED_W-1:0] m_led;
  sys_req_t         seen_req;  // request the DUT sees at the next edge

  rp_top rp_top_i (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .sys_req_i   (sys_req),
    .sys_rsp_o   (sys_rsp),
    .adc_raw_i   (adc_raw),
    .asg_dat_i   (asg_dat),
    .adc_dat_o   (adc_dat),
    .dac_dat_o   (dac_dat),
    .dac_reset_o (dac_reset),
    .led_o       (led)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;  // 20 ns
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic die(string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp)
    else die($sformatf("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  function automatic logic [31:0] xorshift(logic [31:0] s);
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    return s;
  endfunction

  function automatic int sx(logic [SMP_W-1:0] v);  // 14 bit two's complement
    return v[SMP_W-1] ? int'(v) - 16384 : int'(v);
  endfunction

  function automatic sample_t conv(adc_raw_t raw);
    int v;
    v = sx(raw) >>> ADC_SHIFT;  // floor division by 4
    return v[SMP_W-1:0];
  endfunction

  function automatic sample_t sat(sample_t x, sample_t y);
    int s;
    s = sx(x) + sx(y);
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return s[SMP_W-1:0];
  endfunction

  function automatic row_t bus_row(logic wen, logic [31:0] addr, logic [31:0] wdata,
                                   logic [31:0] exp_rdata, logic exp_err);
    row_t r;
    r = '0;
    r.is_bus    = 1'b1;
    r.wen       = wen;
    r.addr      = addr;
    r.wdata     = wdata;
    r.exp_rdata = exp_rdata;
    r.exp_err   = exp_err;
    return r;
  endfunction

  function automatic row_t smp_row(raw_pair_t raw, smp_pair_t asg);
    row_t r;
    r = '0;
    r.raw = raw;
    r.asg = asg;
    return r;
  endfunction

  task automatic push_random(int n);
    row_t r;
    repeat (n)
    begin
      rnd = xorshift(rnd);
      r   = '0;
      r.raw = rnd[27:0];
      rnd = xorshift(rnd);
      r.asg = rnd[27:0];
      tbl.push_back(r);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // model, one call per cycle at the falling edge
  ////////////////////////////////////////////////////////////

  task automatic tick_model();
    logic [REGION_W-1:0]  region;
    logic [REG_OFS_W-1:0] ofs;
    @(negedge adc_clk);
    region = seen_req.addr[22:20];
    ofs    = seen_req.addr[REG_OFS_W-1:0];
    if (seen_req.wen && region == REGION_HK)  // write landed on the last edge
    begin
      if (ofs == HK_ADDR_LOOP) m_loop = seen_req.wdata[0];
      if (ofs == HK_ADDR_LED)  m_led  = seen_req.wdata[LED_W-1:0];
    end
    if (seen_req.wen && region == REGION_DCO)
    begin
      if (ofs == DCO_ADDR_A) m_off.a = seen_req.wdata[SMP_W-1:0];
      if (ofs == DCO_ADDR_B) m_off.b = seen_req.wdata[SMP_W-1:0];
    end
    check_val("adc_dat_o.a", adc_dat.a, exp_adc.a);
    check_val("adc_dat_o.b", adc_dat.b, exp_adc.b);
    check_val("dac_dat_o.a", dac_dat.a, exp_dac2.a);
    check_val("dac_dat_o.b", dac_dat.b, exp_dac2.b);
    check_val("led_o", led, m_led);
    check_val("dac_reset_o", dac_reset, 1'b0);
    // next expectations from the inputs in front of the next edge
    exp_dac2   = exp_dac1;
    exp_dac1.a = sat(asg_dat.a, m_off.a);
    exp_dac1.b = sat(asg_dat.b, m_off.b);
    exp_adc.a  = m_loop ? exp_dac1.a : conv(adc_raw.a);
    exp_adc.b  = m_loop ? exp_dac1.b : conv(adc_raw.b);
    seen_req   = sys_req;
  endtask

  task automatic run_bus(row_t r);
    sys_req_t q;
    int       waited;
    q = '0;
    q.addr  = r.addr;
    q.wdata = r.wdata;
    q.wen   = r.wen;
    q.ren   = ~r.wen;
    @(posedge adc_clk);
    sys_req <= q;
    tick_model();
    assert (!sys_rsp.ack) else die("ack came in the same cycle as the strobe");
    @(posedge adc_clk);
    sys_req <= '0;
    waited = 0;
    do
    begin
      tick_model();
      waited++;
    end while (!sys_rsp.ack && waited < 8);
    assert (sys_rsp.ack) else die($sformatf("no ack for address 0x%0h", r.addr));
    assert (waited == 1) else die("ack did not come one cycle after the strobe");
    check_val("sys_rsp_o.rdata", sys_rsp.rdata, r.exp_rdata);
    check_val("sys_rsp_o.err", sys_rsp.err, r.exp_err);
  endtask

  task automatic run_sample(row_t r);
    @(posedge adc_clk);
    adc_raw <= r.raw;
    asg_dat <= r.asg;
    tick_model();
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////

  task automatic build_table();
    tbl.push_back(bus_row(0, 32'h0000_0000, 0, 32'h5250_0001, 0));  // id
    tbl.push_back(bus_row(1, 32'h0000_0008, 32'hA5, 0, 0));          // leds
    tbl.push_back(bus_row(0, 32'h0000_0008, 0, 32'hA5, 0));
    tbl.push_back(bus_row(1, 32'h0000_0000, 32'hDEAD_BEEF, 0, 0));   // id is read only
    tbl.push_back(bus_row(0, 32'h0000_0000, 0, 32'h5250_0001, 0));
    tbl.push_back(bus_row(0, 32'h0000_000C, 0, 0, 1));               // unknown hk offset
    tbl.push_back(bus_row(1, 32'h0010_0008, 32'h55, 0, 1));           // unknown dco offset
    tbl.push_back(bus_row(0, 32'h0020_0000, 0, 0, 1));               // unmapped regions
    tbl.push_back(bus_row(1, 32'h0070_0010, 32'h1, 0, 1));
    tbl.push_back(bus_row(0, 32'h0050_0004, 0, 0, 1));
    tbl.push_back(bus_row(1, 32'h0010_0000, 32'h0000_1000, 0, 0));   // offset a +4096
    tbl.push_back(bus_row(0, 32'h0010_0000, 0, 32'h0000_1000, 0));
    tbl.push_back(bus_row(1, 32'h0003_E000, 32'h0, 0, 1));           // region 0, high offset
    tbl.push_back(bus_row(1, 32'h0010_0004, 32'h0003_E000, 0, 0));   // offset b -8192
    tbl.push_back(bus_row(0, 32'h0010_0004, 0, 32'hFFFF_E000, 0));
    // saturation both ways, then near full scale
    tbl.push_back(smp_row({14'h1FFF, 14'h2000}, {14'sh1FFF, 14'sh2000}));
    tbl.push_back(smp_row({14'h3FFF, 14'h0003}, {14'sh0FFF, 14'sh1FFF}));
    tbl.push_back(smp_row({14'h2001, 14'h1FFC}, {14'sh2000, 14'sh0000}));
    push_random(6);
    tbl.push_back(bus_row(1, 32'h0010_0000, 32'h0000_3FF0, 0, 0));   // -16
    tbl.push_back(bus_row(0, 32'h0010_0000, 0, 32'hFFFF_FFF0, 0));
    tbl.push_back(bus_row(1, 32'h0010_0004, 32'h0000_0123, 0, 0));
    push_random(6);
    tbl.push_back(bus_row(1, 32'h0000_0004, 32'h1, 0, 0));           // loopback on
    tbl.push_back(bus_row(0, 32'h0000_0004, 0, 32'h1, 0));
    tbl.push_back(smp_row({14'h1FFF, 14'h2000}, {14'sh1FFF, 14'sh2000}));
    push_random(6);
    tbl.push_back(bus_row(1, 32'h0000_0004, 32'h0, 0, 0));           // loopback off
    push_random(3);
    tbl_ready = 1'b1;
  endtask

  initial
  begin
    wait (tbl_ready);
    #(tbl.size() * 20 * 20 + 2000);
    die("watchdog expired, the run did not finish in time");
  end

  initial
  begin
    rst_i    = 1'b1;
    sys_req  = '0;
    adc_raw  = '0;
    asg_dat  = '0;
    m_off    = '0;
    exp_adc  = '0;
    exp_dac1 = '0;
    exp_dac2 = '0;
    m_loop   = 1'b0;
    m_led    = '0;
    seen_req = '0;
    build_table();
    @(posedge adc_clk);
    @(negedge adc_clk);
    check_val("dac_reset_o", dac_reset, 1'b1);  // one cycle behind rst_i
    repeat (2) @(posedge adc_clk);
    rst_i <= 1'b0;  // third reset edge
    @(negedge adc_clk);
    check_val("sys_rsp_o.rdata", sys_rsp.rdata, '0);
    check_val("sys_rsp_o.ack", sys_rsp.ack, '0);
    check_val("sys_rsp_o.err", sys_rsp.err, '0);
    check_val("led_o", led, '0);
    check_val("adc_dat_o", adc_dat, '0);
    check_val("dac_dat_o", dac_dat, '0);
    check_val("dac_reset_o", dac_reset, 1'b1);
    foreach (tbl[i])
    begin
      if (tbl[i].is_bus)
        run_bus(tbl[i]);
      else
        run_sample(tbl[i]);
    end
    repeat (3) tick_model();  // drain the dac pipeline
    $display("Regression passed");
    $finish;
  end

endmodule
